//--- verif/rr_stimulus.txt
# Columns: cmd arg1 arg2 arg3, all hex
# M mode | W/R chan addr data | C cfg_addr expected | S stall_cycles | E end
C 00 00000000
C 04 00000000
W 0 0010 11110000
W 1 0020 22220000
W 0 0014 11110001
W 1 0024 22220001
W 0 0018 11110002
C 04 00000000
M 1
C 00 00000001
W 0 0100 a0000001
W 1 0200 b0000001
W 0 0104 a0000002
W 1 0204 b0000002
W 1 0208 b0000003
S 28
W 0 0108 a0000003
W 1 020c b0000004
W 0 010c a0000004
W 0 0110 a0000005
W 1 0210 b0000005
C 04 0000000a
M 2
C 00 00000002
R 1 0300 c0000001
R 0 0304 c0000002
R 1 0308 c0000003
R 0 030c c0000004
M 3
S 10
R 0 0400 d0000001
R 1 0404 d0000002
R 0 0408 d0000003
R 1 040c d0000004
C 04 0000000e
M 0
C 00 00000000
E

//--- sources.f
hw/rr_pkg.sv
hw/rr_csrs.sv
hw/rr_channel_logger.sv
hw/rr_log_merge.sv
hw/rr_replay_decoder.sv
hw/rr_top.sv
verif/tb_rr_top.sv

//--- Makefile
TOP = tb_rr_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f sources.f

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir

//--- verif/tb_rr_top.sv
module tb_rr_top;
  import rr_pkg::*;

  localparam int NCH         = 2;
  localparam int MODE_STAGES = 3;

  // DUT inputs start at a known value
  logic                     clk          = 1'b0;
  logic                     rst          = 1'b1;
  logic       [NCH-1:0]     sh_valid     = '0;
  wr_req_t    [NCH-1:0]     sh_req       = '0;
  logic       [NCH-1:0]     cl_ready     = '0;
  logic                     log_ready    = 1'b0;
  logic                     replay_valid = 1'b0;
  log_entry_t               replay_entry = '0;
  logic                     cfg_wr       = 1'b0;
  logic                     cfg_rd       = 1'b0;
  cfg_addr_t                cfg_addr     = '0;
  data_t                    cfg_wdata    = '0;

  // DUT outputs
  logic       [NCH-1:0]     sh_ready;
  logic       [NCH-1:0]     cl_valid;
  wr_req_t    [NCH-1:0]     cl_req;
  logic                     log_valid;
  log_entry_t               log_entry;
  logic                     replay_ready;
  data_t                    cfg_rdata;

  // Pending shell and replay traffic
  wr_req_t    sh_q    [NCH][$];
  log_entry_t rp_q    [$];
  // Scoreboards per channel for the user circuit and the log stream
  wr_req_t    exp_cl  [NCH][$];
  log_entry_t exp_log [NCH][$];

  // Mode as seen by the traffic once it has settled
  rr_mode_t cur_mode     = '0;
  logic     mode_settled = 1'b1;
  int       cycle        = 0;
  int       stall_until  = 0;
  int       log_seen     = 0;
  int       n_lines      = 0;
  string    cmds [$];

  always #10 clk = ~clk;

  rr_top #(
    .NUM_CHANNELS(NCH),
    .MODE_STAGES (MODE_STAGES)
  ) i_rr_top (
    .clk(clk), .i_rst(rst),
    .i_sh_valid(sh_valid), .i_sh_req(sh_req), .o_sh_ready(sh_ready),
    .o_cl_valid(cl_valid), .o_cl_req(cl_req), .i_cl_ready(cl_ready),
    .o_log_valid(log_valid), .o_log_entry(log_entry), .i_log_ready(log_ready),
    .i_replay_valid(replay_valid), .i_replay_entry(replay_entry),
    .o_replay_ready(replay_ready),
    .i_cfg_wr(cfg_wr), .i_cfg_rd(cfg_rd), .i_cfg_addr(cfg_addr),
    .i_cfg_wdata(cfg_wdata), .o_cfg_rdata(cfg_rdata)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////////////////////////////////////////
  task automatic finish_failed();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    finish_failed();
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      finish_failed();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drivers on the rising edge
  ////////////////////////////////////////////////////////////////////////////

  // Random stalls on the user circuit and the log stream
  // Stall window forces the log stream low
  initial begin : stall_gen
    void'($urandom(32'h8a260291));
    forever begin
      @(posedge clk);
      cycle     <= cycle + 1;
      log_ready <= (cycle >= stall_until) && ($urandom_range(7) != 0);
      for (int c = 0; c < NCH; c++) begin
        cl_ready[c] <= ($urandom_range(3) != 0);
      end
    end
  end

  // Shell lanes hold valid until accepted
  always @(posedge clk) begin
    for (int c = 0; c < NCH; c++) begin
      if (rst) begin
        sh_valid[c] <= 1'b0;
      end else if (!sh_valid[c] || sh_ready[c]) begin
        if (sh_q[c].size() > 0) begin
          sh_valid[c] <= 1'b1;
          sh_req[c]   <= sh_q[c].pop_front();
        end else begin
          sh_valid[c] <= 1'b0;
        end
      end
    end
  end

  // Replay stream in file order
  always @(posedge clk) begin
    if (rst) begin
      replay_valid <= 1'b0;
    end else if (!replay_valid || replay_ready) begin
      if (rp_q.size() > 0) begin
        replay_valid <= 1'b1;
        replay_entry <= rp_q.pop_front();
      end else begin
        replay_valid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin : monitor
    wr_req_t    want;
    log_entry_t want_log;
    int         lc;
    if (!rst) begin
      // User circuit side in order per channel
      for (int c = 0; c < NCH; c++) begin
        if (cl_valid[c] && cl_ready[c]) begin
          if (exp_cl[c].size() == 0) begin
            abort_run($sformatf("Unexpected user-circuit write on channel %0d", c));
          end else begin
            want = exp_cl[c].pop_front();
            check_value(64'(cl_req[c]), 64'(want), $sformatf("user write, channel %0d", c));
          end
        end
      end
      // Shell is shut out for the whole replay
      if (mode_settled && cur_mode.replay_en) begin
        check_value(64'(sh_ready), 64'(0), "shell ready during replay");
      end
      // Each log entry once and routed by its channel id
      if (log_valid && log_ready) begin
        lc = int'(log_entry.chan);
        if (exp_log[lc].size() == 0) begin
          abort_run($sformatf("Log entry on channel %0d that was never expected", lc));
        end else begin
          want_log = exp_log[lc].pop_front();
          check_value(64'(log_entry), 64'(want_log), $sformatf("log entry, channel %0d", lc));
          log_seen <= log_seen + 1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic is_idle();
    logic idle;
    idle = (sh_valid == '0) && !replay_valid && (rp_q.size() == 0);
    for (int c = 0; c < NCH; c++) begin
      if (sh_q[c].size() != 0 || exp_cl[c].size() != 0 || exp_log[c].size() != 0) begin
        idle = 1'b0;
      end
    end
    return idle;
  endfunction

  task automatic wait_idle();
    while (!is_idle()) begin
      @(posedge clk);
    end
  endtask

  // Mode switches only with no traffic in flight
  task automatic write_mode(input rr_mode_t m);
    wait_idle();
    mode_settled = 1'b0;
    @(posedge clk);
    cfg_wr    <= 1'b1;
    cfg_addr  <= CSR_MODE_ADDR;
    cfg_wdata <= data_t'(m);
    @(posedge clk);
    cfg_wr <= 1'b0;
    // Staging pipe plus the mode register
    repeat (MODE_STAGES + 1) @(posedge clk);
    cur_mode     = m;
    mode_settled = 1'b1;
  endtask

  // Read data comes back the cycle after the strobe
  task automatic read_cfg(input cfg_addr_t addr, output data_t val);
    wait_idle();
    @(posedge clk);
    cfg_rd   <= 1'b1;
    cfg_addr <= addr;
    @(posedge clk);
    cfg_rd <= 1'b0;
    @(posedge clk);
    val = cfg_rdata;
  endtask

  // Queue one shell or replay transfer with its expected results
  task automatic queue_write(input int c, input addr_t wa, input data_t wd,
                             input logic from_replay);
    wr_req_t    req;
    log_entry_t ent;
    req.addr = wa;
    req.data = wd;
    ent.chan = chan_id_t'(c);
    ent.req  = req;
    if (from_replay) begin
      rp_q.push_back(ent);
    end else begin
      sh_q[c].push_back(req);
    end
    exp_cl[c].push_back(req);
    if (cur_mode.record_en) begin
      exp_log[c].push_back(ent);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus file, reset and command loop
  ////////////////////////////////////////////////////////////////////////////
  initial begin : stimulus
    int          fd;
    int          idx;
    logic        ended;
    string       line;
    string       cmd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d;
    data_t       val;
    fd = $fopen("verif/rr_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the stimulus file verif/rr_stimulus.txt");
    end
    // Keep only command lines
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line.getc(0) != "#" && $sscanf(line, "%s", cmd) == 1) begin
        cmds.push_back(line);
      end
    end
    $fclose(fd);
    n_lines = cmds.size();

    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    @(posedge clk);
    check_value(64'(cl_valid), 64'(0), "user valid after reset");
    check_value(64'(log_valid), 64'(0), "log valid after reset");
    check_value(64'(replay_ready), 64'(0), "replay ready after reset");

    idx   = 0;
    ended = 1'b0;
    while (idx < cmds.size() && !ended) begin
      a = '0;
      b = '0;
      d = '0;
      void'($sscanf(cmds[idx], "%s %h %h %h", cmd, a, b, d));
      if (cmd == "M") begin
        write_mode(rr_mode_t'(a[1:0]));
      end else if (cmd == "W") begin
        queue_write(int'(a[0]), b[15:0], d, 1'b0);
      end else if (cmd == "R") begin
        queue_write(int'(a[0]), b[15:0], d, 1'b1);
      end else if (cmd == "C") begin
        read_cfg(a[7:0], val);
        check_value(64'(val), 64'(b), $sformatf("config read at %02h", a[7:0]));
      end else if (cmd == "S") begin
        stall_until = cycle + int'(a);
      end else if (cmd == "E") begin
        ended = 1'b1;
      end else begin
        abort_run($sformatf("Unknown stimulus command on line %0d", idx));
      end
      idx++;
    end

    if (ended) begin
      // Count must match every entry the host side took
      read_cfg(CSR_COUNT_ADDR, val);
      check_value(64'(val), 64'(log_seen), "logged-entry count");
      $display("TEST PASS");
      $finish;
    end else begin
      abort_run("Stimulus file has no end command");
    end
  end

  // Budget grows with the number of stimulus lines
  initial begin : watchdog
    wait (n_lines > 0);
    #((n_lines * 200 + 100) * 20);
    abort_run("Timeout, the DUT stopped making progress");
  end

endmodule

//--- hw/rr_top.sv
module rr_top #(
  parameter int NUM_CHANNELS = 2,
  parameter int MODE_STAGES  = 3
) (
  input  logic                                      clk,
  input  logic                                      i_rst,
  // Shell side, one lane per channel
  input  logic              [NUM_CHANNELS-1:0]      i_sh_valid,
  input  rr_pkg::wr_req_t   [NUM_CHANNELS-1:0]      i_sh_req,
  output logic              [NUM_CHANNELS-1:0]      o_sh_ready,
  // User circuit side
  output logic              [NUM_CHANNELS-1:0]      o_cl_valid,
  output rr_pkg::wr_req_t   [NUM_CHANNELS-1:0]      o_cl_req,
  input  logic              [NUM_CHANNELS-1:0]      i_cl_ready,
  // Log stream toward the host
  output logic                                      o_log_valid,
  output rr_pkg::log_entry_t                        o_log_entry,
  input  logic                                      i_log_ready,
  // Replay stream from the host
  input  logic                                      i_replay_valid,
  input  rr_pkg::log_entry_t                        i_replay_entry,
  output logic                                      o_replay_ready,
  // Config port
  input  logic                                      i_cfg_wr,
  input  logic                                      i_cfg_rd,
  input  rr_pkg::cfg_addr_t                         i_cfg_addr,
  input  rr_pkg::data_t                             i_cfg_wdata,
  output rr_pkg::data_t                             o_cfg_rdata
);
  import rr_pkg::*;

  // Staged mode, same cycle at every channel
  rr_mode_t mode;

  // Decoder slots toward the loggers
  logic       [NUM_CHANNELS-1:0] rp_valid;
  wr_req_t    [NUM_CHANNELS-1:0] rp_req;
  logic       [NUM_CHANNELS-1:0] rp_ready;

  // Logger slots toward the merge
  logic       [NUM_CHANNELS-1:0] lg_valid;
  log_entry_t [NUM_CHANNELS-1:0] lg_entry;
  logic       [NUM_CHANNELS-1:0] lg_ready;

  // Entries handed to the host so far
  count_t log_count;

  ////////////////////////////////////////////////////////////////////////////
  // Control plane
  ////////////////////////////////////////////////////////////////////////////
  rr_csrs #(
    .MODE_STAGES(MODE_STAGES)
  ) u_csrs (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_cfg_wr    (i_cfg_wr),
    .i_cfg_rd    (i_cfg_rd),
    .i_cfg_addr  (i_cfg_addr),
    .i_cfg_wdata (i_cfg_wdata),
    .i_log_count (log_count),
    .o_cfg_rdata (o_cfg_rdata),
    .o_mode      (mode)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Replay stream fan-out by channel id
  ////////////////////////////////////////////////////////////////////////////
  rr_replay_decoder #(
    .NUM_CHANNELS(NUM_CHANNELS)
  ) u_replay_decoder (
    .clk            (clk),
    .i_rst          (i_rst),
    .i_mode         (mode),
    .i_replay_valid (i_replay_valid),
    .i_replay_entry (i_replay_entry),
    .i_cl_ready_rp  (rp_ready),
    .o_replay_ready (o_replay_ready),
    .o_rp_valid     (rp_valid),
    .o_rp_req       (rp_req)
  );

  // One logger per channel, tagged with its own index
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
    rr_channel_logger u_logger (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_mode      (mode),
      .i_sh_valid  (i_sh_valid[c]),
      .i_sh_req    (i_sh_req[c]),
      .i_rp_valid  (rp_valid[c]),
      .i_rp_req    (rp_req[c]),
      .i_cl_ready  (i_cl_ready[c]),
      .i_chan      (chan_id_t'(c)),
      .i_log_ready (lg_ready[c]),
      .o_sh_ready  (o_sh_ready[c]),
      .o_rp_ready  (rp_ready[c]),
      .o_cl_valid  (o_cl_valid[c]),
      .o_cl_req    (o_cl_req[c]),
      .o_log_valid (lg_valid[c]),
      .o_log_entry (lg_entry[c])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Log stream merge
  ////////////////////////////////////////////////////////////////////////////
  rr_log_merge #(
    .NUM_CHANNELS(NUM_CHANNELS)
  ) u_log_merge (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_valid     (lg_valid),
    .i_entry     (lg_entry),
    .i_log_ready (i_log_ready),
    .o_ready     (lg_ready),
    .o_log_valid (o_log_valid),
    .o_log_entry (o_log_entry),
    .o_count     (log_count)
  );

endmodule

//--- hw/rr_replay_decoder.sv
module rr_replay_decoder #(
  parameter int NUM_CHANNELS = 2
) (
  input  logic                                clk,
  input  logic                                i_rst,
  input  rr_pkg::rr_mode_t                    i_mode,
  input  logic                                i_replay_valid,
  input  rr_pkg::log_entry_t                  i_replay_entry,
  // Loggers' replay ready
  input  logic             [NUM_CHANNELS-1:0] i_cl_ready_rp,
  output logic                                o_replay_ready,
  output logic             [NUM_CHANNELS-1:0] o_rp_valid,
  output rr_pkg::wr_req_t  [NUM_CHANNELS-1:0] o_rp_req
);
  import rr_pkg::*;

  // Per-channel holding slots
  logic    [NUM_CHANNELS-1:0] slot_valid;
  wr_req_t [NUM_CHANNELS-1:0] slot_req;

  // Stream entry accepted this cycle
  logic accept;

  // Slot load and drain strobes
  logic [NUM_CHANNELS-1:0] load;
  logic [NUM_CHANNELS-1:0] drain;

  // Target slot must be free, and nothing moves outside replay
  assign o_replay_ready = i_mode.replay_en && !slot_valid[i_replay_entry.chan];
  assign accept         = i_replay_valid && o_replay_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Holding slots
  ////////////////////////////////////////////////////////////////////////////
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_slot
    // Fill needs an empty slot, drain a full one
    assign load[c]  = accept && (int'(i_replay_entry.chan) == c);
    assign drain[c] = slot_valid[c] && i_cl_ready_rp[c];

    always_ff @(posedge clk) begin
      if (i_rst) begin
        slot_valid[c] <= 1'b0;
      end else if (load[c]) begin
        slot_valid[c] <= 1'b1;
      end else if (drain[c]) begin
        slot_valid[c] <= 1'b0;
      end
    end

    always_ff @(posedge clk) begin
      if (load[c]) begin
        slot_req[c] <= i_replay_entry.req;
      end
    end
  end

  // Presented to the logger the cycle after acceptance
  assign o_rp_valid = slot_valid;
  assign o_rp_req   = slot_req;

  // Host trace must only name channels that exist
  a_chan_in_range : assert property (
    @(posedge clk) disable iff (i_rst)
    accept |-> int'(i_replay_entry.chan) < NUM_CHANNELS
  );

endmodule

//--- hw/rr_log_merge.sv
module rr_log_merge #(
  parameter int NUM_CHANNELS = 2
) (
  input  logic                                  clk,
  input  logic                                  i_rst,
  input  logic               [NUM_CHANNELS-1:0] i_valid,
  input  rr_pkg::log_entry_t [NUM_CHANNELS-1:0] i_entry,
  input  logic                                  i_log_ready,
  output logic               [NUM_CHANNELS-1:0] o_ready,
  output logic                                  o_log_valid,
  output rr_pkg::log_entry_t                    o_log_entry,
  output rr_pkg::count_t                        o_count
);
  import rr_pkg::*;

  // Output register may take a new entry
  logic load_ok;

  // Lowest offering channel and its entry
  logic       [NUM_CHANNELS-1:0] grant;
  logic                          found;
  log_entry_t                    sel_entry;

  assign load_ok = !o_log_valid || i_log_ready;

  // Fixed priority with channel 0 first
  always_comb begin
    found     = 1'b0;
    grant     = '0;
    sel_entry = i_entry[0];
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (i_valid[c] && !found) begin
        found     = 1'b1;
        grant[c]  = 1'b1;
        sel_entry = i_entry[c];
      end
    end
  end

  // Grant only when the register can take it
  assign o_ready = load_ok ? grant : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Output register and counter
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_log_valid <= 1'b0;
    end else if (load_ok) begin
      o_log_valid <= found;
    end
  end

  // Holds while the host stalls
  always_ff @(posedge clk) begin
    if (load_ok && found) begin
      o_log_entry <= sel_entry;
    end
  end

  // Counts entries as they leave toward the host
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_count <= '0;
    end else if (o_log_valid && i_log_ready) begin
      o_count <= o_count + count_t'(1);
    end
  end

  // A logger slot stays offered until the merge grants it
  a_offer_held : assert property (
    @(posedge clk) disable iff (i_rst)
    ($past(i_valid & ~o_ready) & ~i_valid) == '0
  );

endmodule

//--- hw/rr_channel_logger.sv
module rr_channel_logger (
  input  logic               clk,
  input  logic               i_rst,
  input  rr_pkg::rr_mode_t   i_mode,
  // Shell source
  input  logic               i_sh_valid,
  input  rr_pkg::wr_req_t    i_sh_req,
  // Replay source from the decoder slot
  input  logic               i_rp_valid,
  input  rr_pkg::wr_req_t    i_rp_req,
  // User circuit back-pressure
  input  logic               i_cl_ready,
  // Own channel id
  input  rr_pkg::chan_id_t   i_chan,
  // Merge grant for this channel
  input  logic               i_log_ready,
  output logic               o_sh_ready,
  output logic               o_rp_ready,
  output logic               o_cl_valid,
  output rr_pkg::wr_req_t    o_cl_req,
  output logic               o_log_valid,
  output rr_pkg::log_entry_t o_log_entry
);
  import rr_pkg::*;

  // Selected source
  logic    src_valid;
  wr_req_t src_req;

  // Channel held while recording and the slot is occupied
  logic blocked;

  // Completed transfer into the user circuit
  logic fire;

  // One-entry log slot
  logic       slot_valid;
  log_entry_t slot_entry;

  ////////////////////////////////////////////////////////////////////////////
  // Source select, shell or replay
  ////////////////////////////////////////////////////////////////////////////
  assign src_valid = i_mode.replay_en ? i_rp_valid : i_sh_valid;
  assign src_req   = i_mode.replay_en ? i_rp_req   : i_sh_req;

  assign blocked = i_mode.record_en && slot_valid;

  // Straight combinational path unless held back by a full slot
  assign o_cl_valid = src_valid && !blocked;
  assign o_cl_req   = src_req;

  // Ready goes back only to the source in use
  // Shell sees ready low for the whole replay
  assign o_sh_ready = !i_mode.replay_en && i_cl_ready && !blocked;
  assign o_rp_ready = i_mode.replay_en && i_cl_ready && !blocked;

  assign fire = o_cl_valid && i_cl_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Log capture
  ////////////////////////////////////////////////////////////////////////////

  // Capture only happens with the slot empty, so fill and drain never collide
  always_ff @(posedge clk) begin
    if (i_rst) begin
      slot_valid <= 1'b0;
    end else if (fire && i_mode.record_en) begin
      slot_valid <= 1'b1;
    end else if (i_log_ready) begin
      slot_valid <= 1'b0;
    end
  end

  // Entry tagged with the channel it went out on
  always_ff @(posedge clk) begin
    if (fire && i_mode.record_en) begin
      slot_entry <= '{chan: i_chan, req: src_req};
    end
  end

  assign o_log_valid = slot_valid;
  assign o_log_entry = slot_entry;

  // Source must hold its request until the user circuit takes it
  a_cl_req_stable : assert property (
    @(posedge clk) disable iff (i_rst)
    o_cl_valid && !i_cl_ready |=> $stable(o_cl_req)
  );

endmodule

//--- hw/rr_csrs.sv
module rr_csrs #(
  parameter int MODE_STAGES = 3
) (
  input  logic              clk,
  input  logic              i_rst,
  input  logic              i_cfg_wr,
  input  logic              i_cfg_rd,
  input  rr_pkg::cfg_addr_t i_cfg_addr,
  input  rr_pkg::data_t     i_cfg_wdata,
  input  rr_pkg::count_t    i_log_count,
  output rr_pkg::data_t     o_cfg_rdata,
  output rr_pkg::rr_mode_t  o_mode
);
  import rr_pkg::*;

  // Mode as written by the host
  rr_mode_t mode_q;

  // Staging pipe, last stage feeds every channel
  rr_mode_t [MODE_STAGES-1:0] mode_pipe;

  // Read data before the output register
  data_t rdata_d;

  ////////////////////////////////////////////////////////////////////////////
  // Mode register
  ////////////////////////////////////////////////////////////////////////////

  // Writes are always accepted, only bits 1:0 are kept
  always_ff @(posedge clk) begin
    if (i_rst) begin
      mode_q <= '0;
    end else if (i_cfg_wr && i_cfg_addr == CSR_MODE_ADDR) begin
      mode_q <= rr_mode_t'(i_cfg_wdata[1:0]);
    end
  end

  // Mode reaches all loggers and the decoder in one and the same cycle
  // Total delay from write strobe is MODE_STAGES+1
  always_ff @(posedge clk) begin
    if (i_rst) begin
      mode_pipe <= '0;
    end else begin
      mode_pipe[0] <= mode_q;
      for (int s = 1; s < MODE_STAGES; s++) begin
        mode_pipe[s] <= mode_pipe[s-1];
      end
    end
  end

  assign o_mode = mode_pipe[MODE_STAGES-1];

  ////////////////////////////////////////////////////////////////////////////
  // Readback
  ////////////////////////////////////////////////////////////////////////////

  // Address decode, holes read as zero
  always_comb begin
    case (i_cfg_addr)
      CSR_MODE_ADDR:  rdata_d = data_t'(mode_q);
      CSR_COUNT_ADDR: rdata_d = data_t'(i_log_count);
      default:        rdata_d = '0;
    endcase
  end

  // Data is valid the cycle after the read strobe
  always_ff @(posedge clk) begin
    if (i_cfg_rd) begin
      o_cfg_rdata <= rdata_d;
    end
  end

  // Host side contract, config reads and writes are separate transfers
  a_no_rd_wr_overlap : assert property (
    @(posedge clk) disable iff (i_rst)
    !(i_cfg_wr && i_cfg_rd)
  );

endmodule

//--- hw/rr_pkg.sv
package rr_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths that carry a meaning
  ////////////////////////////////////////////////////////////////////////////

  // Write address of one channel transaction
  typedef logic [15:0] addr_t;

  // Write data of one channel transaction
  typedef logic [31:0] data_t;

  // Channel index, 0 is ocl and 1 is sda
  typedef logic [0:0] chan_id_t;

  // Number of entries that left on the log stream
  typedef logic [15:0] count_t;

  // Config port address
  typedef logic [7:0] cfg_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Signal groups
  ////////////////////////////////////////////////////////////////////////////

  // One write transaction toward the user circuit
  typedef struct packed {
    addr_t addr;
    data_t data;
  } wr_req_t;

  // Log and replay stream entry
  // Channel id sits on top so the host can route without unpacking
  typedef struct packed {
    chan_id_t chan;
    wr_req_t  req;
  } log_entry_t;

  // Record/replay mode
  // Bit 1 is replay_en, bit 0 is record_en
  typedef struct packed {
    logic replay_en;
    logic record_en;
  } rr_mode_t;

  ////////////////////////////////////////////////////////////////////////////
  // CSR map
  ////////////////////////////////////////////////////////////////////////////

  // Mode register, bits 1:0
  localparam cfg_addr_t CSR_MODE_ADDR = 8'h00;

  // Logged-entry count, read only
  localparam cfg_addr_t CSR_COUNT_ADDR = 8'h04;

endpackage
